// ==== hdl/softermax_pkg.sv ====
// Softermax normalization package
// Shared widths, fraction widths and vector length for the
// normalization stage and its reciprocal pipeline

package softermax_pkg;

  // Vector geometry
  localparam int VEC_LEN    = 8;
  localparam int CNT_WIDTH  = $clog2(VEC_LEN + 1);
  localparam int ADDR_WIDTH = $clog2(VEC_LEN);

  // Input elements, Q1.7
  localparam int ELEM_WIDTH      = 8;
  localparam int ELEM_FRAC_WIDTH = 7;

  // Sum needs three more bits for eight elements
  localparam int SUM_WIDTH      = ELEM_WIDTH + 3;
  localparam int SUM_FRAC_WIDTH = ELEM_FRAC_WIDTH;

  // Reciprocal, Q2.10
  localparam int RECIP_WIDTH      = 12;
  localparam int RECIP_FRAC_WIDTH = 10;

  // Full element times reciprocal product
  localparam int PROD_WIDTH      = ELEM_WIDTH + RECIP_WIDTH;
  localparam int PROD_FRAC_WIDTH = ELEM_FRAC_WIDTH + RECIP_FRAC_WIDTH;

endpackage

// ==== hdl/vec_stream_if.sv ====
// Element stream interface
// One element per beat with valid/ready handshake and a last flag
// on the final element of a vector

`timescale 1ns/1ns

interface vec_stream_if;

  logic [softermax_pkg::ELEM_WIDTH-1:0] data;
  logic                                 valid;
  logic                                 ready;
  logic                                 last;

  modport source (output data, output valid, output last, input ready);
  modport sink   (input data, input valid, input last, output ready);

endinterface

// ==== hdl/skid_buffer.sv ====
// Skid buffer
// Two-entry valid/ready register slice. Upstream ready comes straight
// from a flop, and a beat arriving while the output stalls is parked
// in the skid register

`timescale 1ns/1ns

module skid_buffer #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_valid;
  logic                  in_fire;
  logic                  out_stall;
  logic                  load_main;
  logic                  load_skid;
  logic                  drain_skid;

  assign data_in_ready = !skid_valid;
  assign in_fire       = data_in_valid && data_in_ready;
  assign out_stall     = data_out_valid && !data_out_ready;

  // Main takes the input unless it is stuck, then the skid takes it
  assign load_main  = in_fire && !out_stall;
  assign load_skid  = in_fire && out_stall;
  assign drain_skid = skid_valid && data_out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out_valid <= 1'b0;
      skid_valid     <= 1'b0;
    end else begin
      if (load_main || drain_skid) begin
        data_out_valid <= 1'b1;
      end else if (data_out_ready) begin
        data_out_valid <= 1'b0;
      end
      if (load_skid) begin
        skid_valid <= 1'b1;
      end else if (drain_skid) begin
        skid_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (drain_skid) begin
      data_out <= skid_data;
    end else if (load_main) begin
      data_out <= data_in;
    end
    if (load_skid) begin
      skid_data <= data_in;
    end
  end

endmodule

// ==== hdl/fixed_range_reduction.sv ====
// Range reduction for the reciprocal
// Priority encoder finds the leading one of the sum and shifts it
// to the top bit, so the result reads as Q1.(SUM_WIDTH-1) in [1, 2)

`timescale 1ns/1ns

module fixed_range_reduction (
  input  logic [softermax_pkg::SUM_WIDTH-1:0] data_a,
  output logic [softermax_pkg::SUM_WIDTH-1:0] data_out,
  output logic [3:0]                          msb_index,
  output logic                                not_found
);

  always_comb begin
    msb_index = '0;
    not_found = 1'b1;
    // Highest set bit wins
    for (int i = 0; i < softermax_pkg::SUM_WIDTH; i++) begin
      if (data_a[i]) begin
        msb_index = 4'(i);
        not_found = 1'b0;
      end
    end
    data_out = data_a << (softermax_pkg::SUM_WIDTH - 1 - msb_index);
  end

endmodule

// ==== hdl/softermax_lpw_reciprocal.sv ====
// Linear-piecewise reciprocal
// Five-stage pipelined 1/x on an unsigned Q4.7 sum. The input is range
// reduced into [1, 2), evaluated with chord slope and intercept tables
// over ENTRIES equal segments, shifted back and floored to Q2.10.
// Zero input or overflow saturates to all ones

`timescale 1ns/1ns

module softermax_lpw_reciprocal #(
  parameter int ENTRIES = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [softermax_pkg::SUM_WIDTH-1:0]   in_data,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  output logic [softermax_pkg::RECIP_WIDTH-1:0] out_data,
  output logic                                  out_valid,
  input  logic                                  out_ready
);

  localparam int ENTRIES_WIDTH = $clog2(ENTRIES);
  localparam int MSB_WIDTH     = $clog2(softermax_pkg::SUM_WIDTH);
  localparam int SHIFT_WIDTH   = MSB_WIDTH + 1;

  // Range reduced x, Q1.(SUM_WIDTH-1)
  localparam int RR_WIDTH      = softermax_pkg::SUM_WIDTH;
  localparam int RR_FRAC_WIDTH = RR_WIDTH - 1;

  // Slope precision sets output precision
  localparam int SLOPE_FRAC_WIDTH = softermax_pkg::RECIP_WIDTH;
  localparam int SLOPE_WIDTH      = SLOPE_FRAC_WIDTH + 1;
  localparam int MULT_WIDTH       = RR_WIDTH + SLOPE_WIDTH;
  localparam int MULT_FRAC_WIDTH  = RR_FRAC_WIDTH + SLOPE_FRAC_WIDTH;

  // Intercept aligned to the product, two integer bits
  localparam int ICPT_FRAC_WIDTH = MULT_FRAC_WIDTH;
  localparam int ICPT_WIDTH      = ICPT_FRAC_WIDTH + 2;
  localparam int LPW_WIDTH       = MULT_WIDTH + 1;

  // Headroom so the shift back never loses the integer part
  localparam int SUM_INT_WIDTH = softermax_pkg::SUM_WIDTH - softermax_pkg::SUM_FRAC_WIDTH;
  localparam int EXTRA_WIDTH   = (SUM_INT_WIDTH > softermax_pkg::SUM_FRAC_WIDTH) ?
                                 SUM_INT_WIDTH : softermax_pkg::SUM_FRAC_WIDTH;
  localparam int SHIFTED_WIDTH = LPW_WIDTH + EXTRA_WIDTH;
  localparam int DROP_WIDTH    = MULT_FRAC_WIDTH - softermax_pkg::RECIP_FRAC_WIDTH;
  localparam int KEEP_TOP      = DROP_WIDTH + softermax_pkg::RECIP_WIDTH;

  typedef logic signed [SLOPE_WIDTH-1:0] slope_t;
  typedef logic [ICPT_WIDTH-1:0]         icpt_t;

  slope_t slope_lut [ENTRIES];
  icpt_t  icpt_lut  [ENTRIES];

  logic [RR_WIDTH-1:0]             rr_d, rr_q;
  logic [MSB_WIDTH-1:0]            msb_d, msb_q1, msb_q2;
  logic                            nf_d, nf_q1, nf_q2, nf_q3, nf_q4;
  logic [ENTRIES_WIDTH-1:0]        seg_d, seg_q;
  logic signed [MULT_WIDTH-1:0]    mult_d, mult_q;
  logic [LPW_WIDTH-1:0]            lpw_d, lpw_q;
  logic signed [SHIFT_WIDTH-1:0]   shamt_d, shamt_q;
  logic [SHIFTED_WIDTH-1:0]        shifted_d, shifted_q;
  logic [softermax_pkg::RECIP_WIDTH-1:0] recip_d;
  logic s1_valid, s1_ready, s2_valid, s2_ready;
  logic s3_valid, s3_ready, s4_valid, s4_ready;

  // Chord slope of 1/x between x1 and x2
  function automatic real chord_m(real x1, real x2);
    return (1.0 / x2 - 1.0 / x1) / (x2 - x1);
  endfunction

  initial begin
    real step, x1, x2, m;
    step = 1.0 / ENTRIES;
    for (int i = 0; i < ENTRIES; i++) begin
      x1 = 1.0 + i * step;
      x2 = x1 + step;
      m  = chord_m(x1, x2);
      slope_lut[i] = slope_t'(m * (2.0 ** SLOPE_FRAC_WIDTH));
      icpt_lut[i]  = icpt_t'((1.0 / x1 - m * x1) * (2.0 ** ICPT_FRAC_WIDTH));
    end
  end

  fixed_range_reduction u_range (
    .data_a    (in_data),
    .data_out  (rr_d),
    .msb_index (msb_d),
    .not_found (nf_d)
  );

  skid_buffer #(.DATA_WIDTH(RR_WIDTH + MSB_WIDTH + 1)) u_stage_range (
    .clk, .rst_n,
    .data_in        ({rr_d, msb_d, nf_d}),
    .data_in_valid  (in_valid),
    .data_in_ready  (in_ready),
    .data_out       ({rr_q, msb_q1, nf_q1}),
    .data_out_valid (s1_valid),
    .data_out_ready (s1_ready)
  );

  // Segment index is the top fraction bits of x
  assign seg_d  = rr_q[RR_WIDTH-2 -: ENTRIES_WIDTH];
  assign mult_d = $signed({1'b0, rr_q}) * slope_lut[seg_d];

  skid_buffer #(.DATA_WIDTH(MULT_WIDTH + ENTRIES_WIDTH + MSB_WIDTH + 1)) u_stage_mult (
    .clk, .rst_n,
    .data_in        ({mult_d, seg_d, msb_q1, nf_q1}),
    .data_in_valid  (s1_valid),
    .data_in_ready  (s1_ready),
    .data_out       ({mult_q, seg_q, msb_q2, nf_q2}),
    .data_out_valid (s2_valid),
    .data_out_ready (s2_ready)
  );

  assign lpw_d   = mult_q + $signed({1'b0, icpt_lut[seg_q]});
  assign shamt_d = SHIFT_WIDTH'(softermax_pkg::SUM_FRAC_WIDTH) - SHIFT_WIDTH'(msb_q2);

  skid_buffer #(.DATA_WIDTH(LPW_WIDTH + SHIFT_WIDTH + 1)) u_stage_lpw (
    .clk, .rst_n,
    .data_in        ({lpw_d, shamt_d, nf_q2}),
    .data_in_valid  (s2_valid),
    .data_in_ready  (s2_ready),
    .data_out       ({lpw_q, shamt_q, nf_q3}),
    .data_out_valid (s3_valid),
    .data_out_ready (s3_ready)
  );

  // mx + c is always positive, so a logical shift is enough
  always_comb begin
    if (shamt_q[SHIFT_WIDTH-1]) begin
      shifted_d = SHIFTED_WIDTH'(lpw_q) >> (-shamt_q);
    end else begin
      shifted_d = SHIFTED_WIDTH'(lpw_q) << shamt_q;
    end
  end

  skid_buffer #(.DATA_WIDTH(SHIFTED_WIDTH + 1)) u_stage_shift (
    .clk, .rst_n,
    .data_in        ({shifted_d, nf_q3}),
    .data_in_valid  (s3_valid),
    .data_in_ready  (s3_ready),
    .data_out       ({shifted_q, nf_q4}),
    .data_out_valid (s4_valid),
    .data_out_ready (s4_ready)
  );

  // Floor to Q2.10, saturate on 1/0 or overflow
  assign recip_d = (nf_q4 || |shifted_q[SHIFTED_WIDTH-1:KEEP_TOP]) ?
                   '1 : shifted_q[DROP_WIDTH +: softermax_pkg::RECIP_WIDTH];

  skid_buffer #(.DATA_WIDTH(softermax_pkg::RECIP_WIDTH)) u_stage_out (
    .clk, .rst_n,
    .data_in        (recip_d),
    .data_in_valid  (s4_valid),
    .data_in_ready  (s4_ready),
    .data_out       (out_data),
    .data_out_valid (out_valid),
    .data_out_ready (out_ready)
  );

endmodule

// ==== hdl/norm_fsm.sv ====
// Normalization sequencer
// ACCUM takes input beats, RECIP waits for the reciprocal of the sum,
// SCALE streams the normalized vector out and then starts over

`timescale 1ns/1ns

module norm_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic beat_in,
  input  logic in_last_seen,
  input  logic recip_done,
  input  logic beat_out,
  input  logic rd_last,
  output logic acc_en,
  output logic acc_clr,
  output logic cnt_clr,
  output logic recip_req,
  output logic scale_en
);

  typedef enum logic [1:0] {
    ACCUM,
    RECIP,
    SCALE
  } state_t;

  state_t state, state_next;
  logic   vec_closed;
  logic   vec_done;

  // Closing input beat, and final output transfer
  assign vec_closed = (state == ACCUM) && beat_in && in_last_seen;
  assign vec_done   = (state == SCALE) && beat_out && rd_last;

  always_comb begin
    state_next = state;
    case (state)
      ACCUM:   if (vec_closed) state_next = RECIP;
      RECIP:   if (recip_done) state_next = SCALE;
      SCALE:   if (vec_done) state_next = ACCUM;
      default: state_next = ACCUM;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ACCUM;
      recip_req <= 1'b0;
    end else begin
      state <= state_next;
      // Single request beat, the sum is final by then
      recip_req <= vec_closed;
    end
  end

  assign acc_en   = (state == ACCUM);
  assign scale_en = (state == SCALE);
  assign acc_clr  = vec_done;
  assign cnt_clr  = vec_done;

endmodule

// ==== hdl/elem_counter.sv ====
// Element counter
// Write count tracks elements stored in the vector buffer and is the
// write address. Read index walks them back out on output beats

`timescale 1ns/1ns

module elem_counter (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 cnt_clr,
  input  logic                                 beat_in,
  input  logic                                 beat_out,
  output logic [softermax_pkg::CNT_WIDTH-1:0]  count,
  output logic [softermax_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic                                 rd_last
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count   <= '0;
      rd_addr <= '0;
    end else if (cnt_clr) begin
      count   <= '0;
      rd_addr <= '0;
    end else begin
      if (beat_in && count != softermax_pkg::CNT_WIDTH'(softermax_pkg::VEC_LEN)) begin
        count <= count + 1'b1;
      end
      if (beat_out) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  assign rd_last = (softermax_pkg::CNT_WIDTH'(rd_addr) == count - 1'b1);

endmodule

// ==== hdl/norm_datapath.sv ====
// Normalization datapath
// Buffers the input vector and accumulates its sum. In the scale phase
// each element is multiplied by the held reciprocal, floored back to
// Q1.7, saturated and registered together with its last flag

`timescale 1ns/1ns

module norm_datapath (
  input  logic                                  clk,
  input  logic                                  rst_n,
  vec_stream_if.sink                            in_s,
  vec_stream_if.source                          out_s,
  input  logic                                  acc_en,
  input  logic                                  acc_clr,
  input  logic                                  scale_en,
  input  logic [softermax_pkg::CNT_WIDTH-1:0]   count,
  input  logic [softermax_pkg::ADDR_WIDTH-1:0]  rd_addr,
  input  logic                                  rd_last,
  output logic [softermax_pkg::SUM_WIDTH-1:0]   sum,
  input  logic [softermax_pkg::RECIP_WIDTH-1:0] recip,
  input  logic                                  recip_valid,
  output logic                                  beat_in,
  output logic                                  in_last_seen,
  output logic                                  beat_out
);

  localparam int DROP_WIDTH = softermax_pkg::PROD_FRAC_WIDTH - softermax_pkg::ELEM_FRAC_WIDTH;
  localparam int KEEP_TOP   = DROP_WIDTH + softermax_pkg::ELEM_WIDTH;

  logic [softermax_pkg::ELEM_WIDTH-1:0]  vbuf [softermax_pkg::VEC_LEN];
  logic [softermax_pkg::RECIP_WIDTH-1:0] recip_q;
  logic [softermax_pkg::PROD_WIDTH-1:0]  prod;
  logic [softermax_pkg::ELEM_WIDTH-1:0]  scaled;
  logic [softermax_pkg::ELEM_WIDTH-1:0]  out_data_q;
  logic                                  out_valid_q;
  logic                                  out_last_q;

  assign in_s.ready = acc_en;
  assign beat_in    = in_s.valid && in_s.ready;
  // Vector closes on in_last or when the buffer is about to fill
  assign in_last_seen = in_s.last ||
                        (count == softermax_pkg::CNT_WIDTH'(softermax_pkg::VEC_LEN - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum <= '0;
    end else if (acc_clr) begin
      sum <= '0;
    end else if (beat_in) begin
      sum <= sum + in_s.data;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_in) begin
      vbuf[count[softermax_pkg::ADDR_WIDTH-1:0]] <= in_s.data;
    end
    if (recip_valid) begin
      recip_q <= recip;
    end
  end

  assign prod   = vbuf[rd_addr] * recip_q;
  assign scaled = |prod[softermax_pkg::PROD_WIDTH-1:KEEP_TOP] ?
                  '1 : prod[DROP_WIDTH +: softermax_pkg::ELEM_WIDTH];

  // Output slot reloads one cycle after each transfer, once rd_addr moved on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else if (!scale_en || beat_out) begin
      out_valid_q <= 1'b0;
    end else if (!out_valid_q) begin
      out_valid_q <= 1'b1;
      out_last_q  <= rd_last;
    end
  end

  always_ff @(posedge clk) begin
    if (scale_en && !out_valid_q) begin
      out_data_q <= scaled;
    end
  end

  assign out_s.data  = out_data_q;
  assign out_s.valid = out_valid_q;
  assign out_s.last  = out_last_q;
  assign beat_out    = out_s.valid && out_s.ready;

endmodule

// ==== hdl/softermax_norm.sv ====
// Softermax normalization stage
// Sums an input vector of exponents, takes the reciprocal of the sum
// and streams each element times that reciprocal back out

`timescale 1ns/1ns

module softermax_norm (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] in_data,
  input  logic       in_valid,
  input  logic       in_last,
  output logic       in_ready,
  output logic [7:0] out_data,
  output logic       out_valid,
  output logic       out_last,
  input  logic       out_ready
);

  vec_stream_if in_if ();
  vec_stream_if out_if ();

  logic                                  acc_en, acc_clr, cnt_clr;
  logic                                  recip_req, scale_en;
  logic                                  beat_in, in_last_seen, beat_out;
  logic [softermax_pkg::CNT_WIDTH-1:0]   count;
  logic [softermax_pkg::ADDR_WIDTH-1:0]  rd_addr;
  logic                                  rd_last;
  logic [softermax_pkg::SUM_WIDTH-1:0]   sum;
  logic [softermax_pkg::RECIP_WIDTH-1:0] recip;
  logic                                  recip_valid;

  assign in_if.data  = in_data;
  assign in_if.valid = in_valid;
  assign in_if.last  = in_last;
  assign in_ready    = in_if.ready;

  assign out_data     = out_if.data;
  assign out_valid    = out_if.valid;
  assign out_last     = out_if.last;
  assign out_if.ready = out_ready;

  norm_fsm u_fsm (
    .clk, .rst_n,
    .beat_in, .in_last_seen,
    .recip_done (recip_valid),
    .beat_out, .rd_last,
    .acc_en, .acc_clr, .cnt_clr, .recip_req, .scale_en
  );

  elem_counter u_counter (
    .clk, .rst_n,
    .cnt_clr, .beat_in, .beat_out,
    .count, .rd_addr, .rd_last
  );

  norm_datapath u_datapath (
    .clk, .rst_n,
    .in_s  (in_if.sink),
    .out_s (out_if.source),
    .acc_en, .acc_clr, .scale_en,
    .count, .rd_addr, .rd_last,
    .sum, .recip, .recip_valid,
    .beat_in, .in_last_seen, .beat_out
  );

  // One request per vector into an empty pipe, so it is always taken
  softermax_lpw_reciprocal #(.ENTRIES(8)) u_recip (
    .clk, .rst_n,
    .in_data   (sum),
    .in_valid  (recip_req),
    .in_ready  (),
    .out_data  (recip),
    .out_valid (recip_valid),
    .out_ready (1'b1)
  );

endmodule

// ==== test/softermax_norm_tb.sv ====
// Testbench for the softermax normalization stage
// Applies a table of vectors and checks every output beat against a
// bit-exact model of the reciprocal and scale rules, with random
// back-pressure on the output stream

`timescale 1ns/1ns

module softermax_norm_tb;

  localparam int NUM_VECS   = 7;
  localparam int WAIT_LIMIT = 100;

  logic       clk;
  logic       rst_n;
  logic [7:0] in_data;
  logic       in_valid;
  logic       in_last;
  logic       in_ready;
  logic [7:0] out_data;
  logic       out_valid;
  logic       out_last;
  logic       out_ready;
  integer     seed;
  integer     rnd;

  // Element 0 sits in the low byte
  logic [63:0] tbl_elems [NUM_VECS] = '{
    64'h7F08_2818_4030_2010,
    64'h0000_0000_0000_0080,
    64'h0000_0000_00C0_2A55,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0002_0804,
    64'hFFFF_FFFF_FFFF_FFFF,
    64'h0000_0025_DA6E_0391
  };
  int          tbl_len [NUM_VECS] = '{8, 1, 3, 4, 3, 8, 5};
  // Expected Q4.7 sum of each vector
  logic [10:0] tbl_sum [NUM_VECS] = '{
    11'h167, 11'h080, 11'h13F, 11'h000, 11'h00E, 11'h7F8, 11'h201
  };

  softermax_norm u_dut (
    .clk, .rst_n,
    .in_data, .in_valid, .in_last, .in_ready,
    .out_data, .out_valid, .out_last, .out_ready
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout: %s", what);
    $display("TEST FAIL");
    $fatal(1, "wait limit reached");
  endtask

  // 1/x by range reduction and chords of 1/x over eight segments of [1, 2)
  function automatic logic [11:0] expected_recip(input logic [10:0] s);
    real         x1;
    real         x2;
    real         m;
    longint      slope;
    longint      icpt;
    longint      lpw;
    longint      shifted;
    int          msb;
    int          shamt;
    int          seg;
    logic [10:0] rr;
    if (s == '0) begin
      return 12'hFFF;
    end
    msb = 0;
    for (int i = 0; i < 11; i++) begin
      if (s[i]) msb = i;
    end
    rr    = s << (10 - msb);
    seg   = rr[9:7];
    x1    = 1.0 + seg / 8.0;
    x2    = x1 + 0.125;
    m     = (1.0 / x2 - 1.0 / x1) / (x2 - x1);
    slope = m * 4096.0;
    icpt  = (1.0 / x1 - m * x1) * 4194304.0;
    lpw   = longint'(rr) * slope + icpt;
    shamt = 7 - msb;
    if (shamt < 0) begin
      shifted = lpw >> (-shamt);
    end else begin
      shifted = lpw << shamt;
    end
    shifted = shifted & 64'hFFFF_FFFF;
    // Q2.10 holds values below four
    if ((shifted >> 24) != 0) begin
      return 12'hFFF;
    end
    return 12'((shifted >> 12) & 64'hFFF);
  endfunction

  // Q1.7 times Q2.10, floored back to Q1.7 and clipped
  function automatic logic [7:0] scale_elem(input logic [7:0] e, input logic [11:0] r);
    int prod;
    prod = e * r;
    if ((prod >> 18) != 0) begin
      return 8'hFF;
    end
    return 8'(prod >> 10);
  endfunction

  task automatic send_vector(input int v);
    int n;
    for (int i = 0; i < tbl_len[v]; i++) begin
      in_data  <= tbl_elems[v][8*i +: 8];
      in_valid <= 1'b1;
      in_last  <= (i == tbl_len[v] - 1);
      n = 0;
      @(negedge clk);
      while (!in_ready) begin
        @(negedge clk);
        n++;
        if (n > WAIT_LIMIT) fail_timeout("input element was never accepted");
      end
      // Beat transfers on this edge
      @(posedge clk);
    end
    in_valid <= 1'b0;
    in_last  <= 1'b0;
  endtask

  task automatic collect_vector(input int v);
    logic [11:0] recip;
    int          idx;
    int          n;
    recip = expected_recip(tbl_sum[v]);
    idx   = 0;
    n     = 0;
    while (idx < tbl_len[v]) begin
      @(posedge clk);
      rnd = $random(seed);
      out_ready <= rnd[0];
      @(negedge clk);
      // Input stays closed until the last output has gone
      check_value("in_ready", in_ready, 1'b0);
      if (out_valid && out_ready) begin
        check_value("out_data", out_data, scale_elem(tbl_elems[v][8*idx +: 8], recip));
        check_value("out_last", out_last, idx == tbl_len[v] - 1);
        idx++;
        n = 0;
      end else begin
        n++;
        if (n > WAIT_LIMIT) fail_timeout("output element did not arrive");
      end
    end
    @(posedge clk);
    out_ready <= 1'b0;
    @(negedge clk);
    check_value("out_valid", out_valid, 1'b0);
    check_value("in_ready", in_ready, 1'b1);
  endtask

  initial begin
    seed      = 32'h579e2482;
    rst_n     = 1'b0;
    in_data   = '0;
    in_valid  = 1'b0;
    in_last   = 1'b0;
    out_ready = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("out_valid", out_valid, 1'b0);
    check_value("in_ready", in_ready, 1'b1);
    @(posedge clk);
    for (int v = 0; v < NUM_VECS; v++) begin
      send_vector(v);
      @(negedge clk);
      check_value("sum", u_dut.sum, tbl_sum[v]);
      // Input closes in the cycle after the closing beat
      check_value("in_ready", in_ready, 1'b0);
      collect_vector(v);
      @(posedge clk);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/softermax_pkg.sv
hdl/vec_stream_if.sv
hdl/skid_buffer.sv
hdl/fixed_range_reduction.sv
hdl/softermax_lpw_reciprocal.sv
hdl/norm_fsm.sv
hdl/elem_counter.sv
hdl/norm_datapath.sv
hdl/softermax_norm.sv
test/softermax_norm_tb.sv

// ==== Bender.yml ====
package:
  name: softermax_norm

sources:
  - hdl/softermax_pkg.sv
  - hdl/vec_stream_if.sv
  - hdl/skid_buffer.sv
  - hdl/fixed_range_reduction.sv
  - hdl/softermax_lpw_reciprocal.sv
  - hdl/norm_fsm.sv
  - hdl/elem_counter.sv
  - hdl/norm_datapath.sv
  - hdl/softermax_norm.sv
  - target: test
    files:
      - test/softermax_norm_tb.sv
